// ==== verilog/pulser_pkg.sv ====
// Widths, pipeline latency and register map for the feedforward pulser
// Setpoints are signed DWI bits and the slew limit is one bit narrower
// The Wishbone data bus is fixed at 32 bits
`default_nettype none

package pulser_pkg;

   // Datapath widths
   localparam int LENGTH_WI = 20;         // Pulse length and its counters
   localparam int DWI       = 18;         // Signed setpoints and outputs
   localparam int SLEW_WI   = DWI - 1;    // Unsigned slew limit

   // Bus widths
   localparam int ADR_WI = 3;             // Word address
   localparam int WB_DWI = 32;

   // Timing
   localparam int PIPE_LAT    = 3;        // Pulse start to first ramp step
   localparam int FALL_MARGIN = 5;        // Subtracted from the fall point

   // Register map, word addresses
   localparam logic [ADR_WI-1:0] REG_LENGTH = 3'd0;
   localparam logic [ADR_WI-1:0] REG_SLEW   = 3'd1;
   localparam logic [ADR_WI-1:0] REG_SETP_X = 3'd2;
   localparam logic [ADR_WI-1:0] REG_SETP_Y = 3'd3;
   localparam logic [ADR_WI-1:0] REG_STATUS = 3'd4;  // Read only, bit 0 is busy

endpackage

`default_nettype wire

// ==== verilog/pulse_regs.sv ====
// Wishbone classic slave for the pulse settings
// Acknowledges every access one cycle after cyc and stb are seen
// Settings are expected to change only while no pulse is running
// Unmapped reads return zero, writes to status or unmapped words are dropped
`timescale 1ns/10ps
`default_nettype none

module pulse_regs (
   input  wire                                    clk,
   input  wire                                    reset,
   // Wishbone classic slave
   input  wire                                    wb_cyc,
   input  wire                                    wb_stb,
   input  wire                                    wb_we,
   input  wire         [pulser_pkg::ADR_WI-1:0]   wb_adr,
   input  wire         [pulser_pkg::WB_DWI-1:0]   wb_dat_w,
   output logic        [pulser_pkg::WB_DWI-1:0]   wb_dat_r,
   output logic                                   wb_ack,
   // Status from the sequencer
   input  wire                                    busy,
   // Settings
   output logic        [pulser_pkg::LENGTH_WI-1:0] length,
   output logic        [pulser_pkg::SLEW_WI-1:0]   slew_limit,
   output logic signed [pulser_pkg::DWI-1:0]       setp_x,
   output logic signed [pulser_pkg::DWI-1:0]       setp_y
);
   import pulser_pkg::*;

   logic                access;  // New request this cycle
   logic                wr_en;
   logic [WB_DWI-1:0]   rd_mux;

   // A request still held after its ack is not a new one
   assign access = wb_cyc & wb_stb & ~wb_ack;
   assign wr_en  = access & wb_we;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;
      end
   end

   // Settings registers, truncated to their widths
   always_ff @(posedge clk) begin
      if (reset) begin
         length     <= '0;
         slew_limit <= '0;
         setp_x     <= '0;
         setp_y     <= '0;
      end else if (wr_en) begin
         case (wb_adr)
            REG_LENGTH: length     <= wb_dat_w[LENGTH_WI-1:0];
            REG_SLEW:   slew_limit <= wb_dat_w[SLEW_WI-1:0];
            REG_SETP_X: setp_x     <= $signed(wb_dat_w[DWI-1:0]);
            REG_SETP_Y: setp_y     <= $signed(wb_dat_w[DWI-1:0]);
            default: ;  // Status and unmapped words are read only
         endcase
      end
   end

   // Readback, setpoints sign-extended to the bus width
   always_comb begin
      case (wb_adr)
         REG_LENGTH: rd_mux = {{(WB_DWI-LENGTH_WI){1'b0}}, length};
         REG_SLEW:   rd_mux = {{(WB_DWI-SLEW_WI){1'b0}}, slew_limit};
         REG_SETP_X: rd_mux = {{(WB_DWI-DWI){setp_x[DWI-1]}}, setp_x};
         REG_SETP_Y: rd_mux = {{(WB_DWI-DWI){setp_y[DWI-1]}}, setp_y};
         REG_STATUS: rd_mux = {{(WB_DWI-1){1'b0}}, busy};
         default:    rd_mux = '0;
      endcase
   end

   // Captured with the ack so it is steady while ack is high
   always_ff @(posedge clk) begin
      if (access) begin
         wb_dat_r <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pulse_sequencer.sv ====
// Pulse sequencer, the control side of the feedforward pulser
// A trigger while idle starts a pulse; busy then lasts length + 4 cycles
// Triggers during a pulse are ignored
// Length must leave room for a flat top, or the fall point wraps
`timescale 1ns/10ps
`default_nettype none

module pulse_sequencer (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                trigger,
   input  wire [pulser_pkg::LENGTH_WI-1:0]    length,
   input  wire                                railed_x,  // Already pipeline aligned
   input  wire                                railed_y,
   output logic                               pulse_on,
   output logic                               ramp_en,
   output logic                               fall,
   output logic                               busy
);
   import pulser_pkg::*;

   logic [PIPE_LAT-1:0]   on_pipe;      // Latency match for the active flag
   logic [LENGTH_WI-1:0]  len_cnt;      // Ramp cycles elapsed
   logic [LENGTH_WI-1:0]  rise_cnt;     // Cycles until both channels railed
   logic [LENGTH_WI-1:0]  fall_t;       // Length count where the fall begins
   logic                  fall_t_valid;
   logic                  start;
   logic                  both_railed;
   logic                  counting;

   assign start       = trigger & ~pulse_on;
   assign both_railed = railed_x & railed_y;
   assign counting    = pulse_on & ramp_en;

   assign ramp_en = on_pipe[PIPE_LAT-1];
   assign busy    = pulse_on;

   always_ff @(posedge clk) begin
      if (reset) begin
         on_pipe <= '0;
      end else if (start) begin
         on_pipe <= '0;  // Flush the tail of a previous pulse
      end else begin
         on_pipe <= {on_pipe[PIPE_LAT-2:0], pulse_on};
      end
   end

   // Active flag and the fall phase
   always_ff @(posedge clk) begin
      if (reset) begin
         pulse_on <= 1'b0;
         fall     <= 1'b0;
      end else if (start) begin
         pulse_on <= 1'b1;
         fall     <= 1'b0;
      end else if (counting) begin
         if (len_cnt == length) begin  // Length strictly enforced
            pulse_on <= 1'b0;
            fall     <= 1'b0;
         end else if (fall_t_valid && (len_cnt == fall_t)) begin
            fall <= 1'b1;
         end
      end
   end

   // Counters and the fall point
   always_ff @(posedge clk) begin
      if (reset) begin
         len_cnt      <= '0;
         rise_cnt     <= '0;
         fall_t       <= '0;
         fall_t_valid <= 1'b0;
      end else if (start) begin
         len_cnt      <= '0;
         rise_cnt     <= '0;
         fall_t       <= '0;
         fall_t_valid <= 1'b0;
      end else if (counting) begin
         len_cnt <= len_cnt + 1'b1;
         if (!fall_t_valid) begin
            if (both_railed) begin
               // Mirror the rise time at the end of the pulse
               fall_t       <= length - rise_cnt - LENGTH_WI'(FALL_MARGIN);
               fall_t_valid <= 1'b1;
            end else begin
               rise_cnt <= rise_cnt + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/slew_channel.sv ====
// One setpoint channel of the pulser, magnitude ramp plus sign restore
// Steps by slew_limit per cycle while ramp_en is high, clamped at the
// setpoint magnitude on the rise and at zero on the fall
// The most negative setpoint saturates to the largest magnitude
// A slew limit of zero never leaves zero
`timescale 1ns/10ps
`default_nettype none

module slew_channel (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                pulse_on,
   input  wire                                ramp_en,
   input  wire                                fall,
   input  wire        [pulser_pkg::SLEW_WI-1:0] slew_limit,
   input  wire signed [pulser_pkg::DWI-1:0]   setp,
   output logic                               railed_r,
   output logic signed [pulser_pkg::DWI-1:0]  out
);
   import pulser_pkg::*;

   logic [DWI-1:0]  setp_abs;   // Wide enough for the most negative value
   logic [DWI-2:0]  setp_mag;
   logic            setp_neg;
   logic [DWI-2:0]  mag;        // Magnitude accumulator
   logic [DWI-1:0]  rise_sum;   // One bit of headroom over mag
   logic            at_setp;
   logic            railed;

   assign setp_abs = setp[DWI-1] ? $unsigned(-setp) : $unsigned(setp);

   // Setpoint magnitude and sign, first stage
   always_ff @(posedge clk) begin
      setp_mag <= setp_abs[DWI-1] ? '1 : setp_abs[DWI-2:0];
      setp_neg <= setp[DWI-1];
   end

   assign rise_sum = {1'b0, mag} + {1'b0, slew_limit};
   assign at_setp  = rise_sum >= {1'b0, setp_mag};

   always_ff @(posedge clk) begin
      if (reset || !pulse_on) begin
         mag    <= '0;
         railed <= 1'b0;
      end else if (ramp_en) begin
         if (!fall) begin
            if (at_setp) begin
               mag    <= setp_mag;  // Clamp at the top
               railed <= 1'b1;
            end else begin
               mag    <= rise_sum[DWI-2:0];
            end
         end else begin
            railed <= 1'b0;
            // Clamp at zero, then stays there
            if (mag <= slew_limit) mag <= '0;
            else                   mag <= mag - slew_limit;
         end
      end
   end

   // Extra stage so railed lines up with the sequencer counters
   always_ff @(posedge clk) begin
      if (reset || !pulse_on) begin
         railed_r <= 1'b0;
      end else begin
         railed_r <= railed;
      end
   end

   // Sign restore, output register
   always_ff @(posedge clk) begin
      if (reset) begin
         out <= '0;
      end else if (setp_neg) begin
         out <= -$signed({1'b0, mag});
      end else begin
         out <= $signed({1'b0, mag});
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ff_pulser_top.sv ====
// Feedforward pulser, drives a coherent pair of setpoints through a
// trapezoid on each trigger
// Settings come from a Wishbone classic slave and are assumed static
// during a pulse; first nonzero output is 5 cycles after busy rises
`timescale 1ns/10ps
`default_nettype none

module ff_pulser_top (
   input  wire                                clk,
   input  wire                                reset,
   // Wishbone classic slave
   input  wire                                wb_cyc,
   input  wire                                wb_stb,
   input  wire                                wb_we,
   input  wire        [pulser_pkg::ADR_WI-1:0] wb_adr,
   input  wire        [pulser_pkg::WB_DWI-1:0] wb_dat_w,
   output logic       [pulser_pkg::WB_DWI-1:0] wb_dat_r,
   output logic                               wb_ack,
   // Pulse control and outputs
   input  wire                                trigger,
   output logic                               busy,
   output logic signed [pulser_pkg::DWI-1:0]  out_x,
   output logic signed [pulser_pkg::DWI-1:0]  out_y
);
   import pulser_pkg::*;

   logic [LENGTH_WI-1:0]     length;
   logic [SLEW_WI-1:0]       slew_limit;
   logic signed [DWI-1:0]    setp_x;
   logic signed [DWI-1:0]    setp_y;
   logic                     pulse_on;
   logic                     ramp_en;
   logic                     fall;
   logic                     railed_x;
   logic                     railed_y;

   pulse_regs pulse_regs_i (
      .clk        (clk),
      .reset      (reset),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .busy       (busy),
      .length     (length),
      .slew_limit (slew_limit),
      .setp_x     (setp_x),
      .setp_y     (setp_y)
   );

   pulse_sequencer pulse_sequencer_i (
      .clk      (clk),
      .reset    (reset),
      .trigger  (trigger),
      .length   (length),
      .railed_x (railed_x),
      .railed_y (railed_y),
      .pulse_on (pulse_on),
      .ramp_en  (ramp_en),
      .fall     (fall),
      .busy     (busy)
   );

   slew_channel chan_x_i (
      .clk        (clk),
      .reset      (reset),
      .pulse_on   (pulse_on),
      .ramp_en    (ramp_en),
      .fall       (fall),
      .slew_limit (slew_limit),
      .setp       (setp_x),
      .railed_r   (railed_x),
      .out        (out_x)
   );

   slew_channel chan_y_i (
      .clk        (clk),
      .reset      (reset),
      .pulse_on   (pulse_on),
      .ramp_en    (ramp_en),
      .fall       (fall),
      .slew_limit (slew_limit),
      .setp       (setp_y),
      .railed_r   (railed_y),
      .out        (out_y)
   );

endmodule

`default_nettype wire

// ==== sim/ff_pulser_checker.sv ====
// Concurrent checks on one slew channel, attached with bind
// Assumes settings do not change while the channel output is nonzero
`timescale 1ns/10ps
`default_nettype none

module ff_pulser_checker (
   input  wire                                 clk,
   input  wire                                 reset,
   input  wire                                 pulse_on,
   input  wire        [pulser_pkg::SLEW_WI-1:0] slew_limit,
   input  wire signed [pulser_pkg::DWI-1:0]    setp,
   input  wire        [pulser_pkg::DWI-2:0]    mag,
   input  wire signed [pulser_pkg::DWI-1:0]    out
);
   import pulser_pkg::*;

   logic [DWI-2:0]  mag_d;       // Magnitude one cycle back
   logic [DWI-2:0]  mag_step;
   logic            pulse_on_d;
   logic            pulse_on_d2;
   int              fail_count = 0;  // Failed assertions so far

   always_ff @(posedge clk) begin
      if (reset) begin
         mag_d       <= '0;
         pulse_on_d  <= 1'b0;
         pulse_on_d2 <= 1'b0;
      end else begin
         mag_d       <= mag;
         pulse_on_d  <= pulse_on;
         pulse_on_d2 <= pulse_on_d;
      end
   end

   assign mag_step = (mag >= mag_d) ? mag - mag_d : mag_d - mag;

   // Clearing at the pulse end is exempt
   slew_bound: assert property (@(posedge clk) disable iff (reset)
      pulse_on_d |-> (mag_step <= slew_limit))
      else begin
         $error("magnitude step larger than the slew limit");
         fail_count++;
      end

   sign_match: assert property (@(posedge clk) disable iff (reset)
      (out != '0) |-> (out[DWI-1] == setp[DWI-1]))
      else begin
         $error("output sign opposite to the setpoint");
         fail_count++;
      end

   idle_zero: assert property (@(posedge clk) disable iff (reset)
      (!pulse_on_d && !pulse_on_d2) |-> (out == '0))
      else begin
         $error("output nonzero with the pulse off");
         fail_count++;
      end

endmodule

`default_nettype wire

// ==== sim/ff_pulser_tb.sv ====
// Table-driven testbench for the feedforward pulser
// Each row writes the settings, reads them back and runs one pulse,
// checking busy timing and both outputs every cycle
// Rows need a length that leaves room for rise and fall
`timescale 1ns/10ps
`default_nettype none

module ff_pulser_tb;
   import pulser_pkg::*;

   localparam int NUM_ROWS   = 5;
   localparam int EXTRA_AT   = 20;   // Cycle of the ignored second trigger
   localparam int ZERO_CHECK = 5;    // Idle cycles checked after a pulse

   logic                     clk;
   logic                     reset;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [ADR_WI-1:0]        wb_adr;
   logic [WB_DWI-1:0]        wb_dat_w;
   logic [WB_DWI-1:0]        wb_dat_r;
   logic                     wb_ack;
   logic                     trigger;
   logic                     busy;
   logic signed [DWI-1:0]    out_x;
   logic signed [DWI-1:0]    out_y;

   // Stimulus table, last row filled at random
   int  row_len   [NUM_ROWS] = '{100, 150, 120, 60, 0};
   int  row_slew  [NUM_ROWS] = '{1000, 2500, 3000, 50000, 0};
   int  row_x     [NUM_ROWS] = '{20000, -30000, 25000, 4000, 0};
   int  row_y     [NUM_ROWS] = '{15000, -40000, -18000, -7000, 0};
   bit  row_extra [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

   int  seed = 89;
   int  value_errors = 0;
   int  bus_errors = 0;
   int  assert_errors = 0;
   int  limit_cycles = 0;
   bit  limit_ready = 1'b0;
   int  prev_mag [2];
   bit  peaked   [2];

   ff_pulser_top ff_pulser_top_i (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .trigger  (trigger),
      .busy     (busy),
      .out_x    (out_x),
      .out_y    (out_y)
   );

   bind slew_channel ff_pulser_checker checker_i (
      .clk        (clk),
      .reset      (reset),
      .pulse_on   (pulse_on),
      .slew_limit (slew_limit),
      .setp       (setp),
      .mag        (mag),
      .out        (out)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic expect_equal(input string what, input int got, input int exp);
      assert (got == exp) else begin
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
         value_errors++;
      end
   endtask

   // Single access, called at a falling edge and returns at one
   task automatic bus_access(input logic [ADR_WI-1:0] adr, input bit we,
                             input logic [WB_DWI-1:0] wdata,
                             output logic [WB_DWI-1:0] rdata);
      int tries;
      tries = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      rdata    = '0;
      do begin
         @(negedge clk);
         tries++;
      end while (!wb_ack && tries < 8);
      if (wb_ack) begin
         rdata = wb_dat_r;
      end else begin
         $display("Bus access to address %0d got no acknowledge", adr);
         bus_errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [ADR_WI-1:0] adr, input int data);
      logic [WB_DWI-1:0] dummy;
      bus_access(adr, 1'b1, data, dummy);
   endtask

   task automatic read_and_compare(input logic [ADR_WI-1:0] adr, input string what,
                                   input int exp);
      logic [WB_DWI-1:0] rdata;
      bus_access(adr, 1'b0, '0, rdata);
      expect_equal(what, rdata, exp);
   endtask

   // Exact ramp while rising, bounded steps once at the peak
   task automatic check_channel(input int ch, input int c, input int out_v,
                                input int setp_v, input int slew_v);
      int mag_v;
      int m;
      int exp;
      mag_v = (out_v < 0) ? -out_v : out_v;
      m = (setp_v < 0) ? -setp_v : setp_v;
      if (out_v != 0) begin
         assert ((out_v < 0) == (setp_v < 0)) else begin
            $display("[ERROR] %0t: channel %0d sign wrong, out %0d setp %0d",
                     $time, ch, out_v, setp_v);
            value_errors++;
         end
      end
      if (!peaked[ch]) begin
         exp = (c < PIPE_LAT + 3) ? 0 : (c - PIPE_LAT - 2) * slew_v;
         if (exp > m) exp = m;
         expect_equal($sformatf("channel %0d magnitude at cycle %0d", ch, c), mag_v, exp);
         if (mag_v == m) peaked[ch] = 1'b1;
      end else begin
         assert (mag_v <= prev_mag[ch] && prev_mag[ch] - mag_v <= slew_v) else begin
            $display("[ERROR] %0t: channel %0d bad fall step %0d to %0d",
                     $time, ch, prev_mag[ch], mag_v);
            value_errors++;
         end
      end
      prev_mag[ch] = mag_v;
   endtask

   task automatic check_both(input int i, input int c);
      check_channel(0, c, out_x, row_x[i], row_slew[i]);
      check_channel(1, c, out_y, row_y[i], row_slew[i]);
   endtask

   task automatic run_row(input int i);
      int c;
      int busy_cycles;
      bus_write(REG_LENGTH, row_len[i]);
      bus_write(REG_SLEW, row_slew[i]);
      bus_write(REG_SETP_X, row_x[i]);
      bus_write(REG_SETP_Y, row_y[i]);
      read_and_compare(REG_LENGTH, "length readback", row_len[i]);
      read_and_compare(REG_SLEW, "slew readback", row_slew[i]);
      read_and_compare(REG_SETP_X, "setp_x readback", row_x[i]);
      read_and_compare(REG_SETP_Y, "setp_y readback", row_y[i]);
      read_and_compare(REG_STATUS, "idle status", 0);
      read_and_compare(3'd6, "unmapped readback", 0);

      trigger = 1'b1;
      @(negedge clk);
      trigger = 1'b0;
      c = 1;
      busy_cycles = 0;
      prev_mag = '{0, 0};
      peaked = '{1'b0, 1'b0};
      fork
         begin
            repeat (8) @(negedge clk);
            read_and_compare(REG_STATUS, "busy status", 1);
         end
         begin
            forever begin
               check_both(i, c);
               if (!busy) break;
               busy_cycles++;
               trigger = row_extra[i] && (c == EXTRA_AT);
               @(negedge clk);
               c++;
            end
            trigger = 1'b0;
         end
      join
      expect_equal($sformatf("busy length, row %0d", i), busy_cycles, row_len[i] + 4);
      @(negedge clk);
      c++;
      check_both(i, c);
      @(negedge clk);
      c++;
      // Fall steps stay bounded into the idle zeros
      repeat (ZERO_CHECK) begin
         check_both(i, c);
         expect_equal("out_x after pulse", out_x, 0);
         expect_equal("out_y after pulse", out_y, 0);
         @(negedge clk);
         c++;
      end
      assert (peaked[0] && peaked[1]) else begin
         $display("[ERROR] %0t: row %0d never reached a setpoint", $time, i);
         value_errors++;
      end
   endtask

   // Watchdog, sized from the table
   initial begin
      wait (limit_ready);
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      trigger  = 1'b0;

      row_len[NUM_ROWS-1]   = 600 + ($random(seed) & 255);
      row_slew[NUM_ROWS-1]  = 500 + ($random(seed) & 2047);
      row_x[NUM_ROWS-1]     = $random(seed) % 100000;
      row_y[NUM_ROWS-1]     = $random(seed) % 100000;
      row_extra[NUM_ROWS-1] = $random(seed) & 1;
      limit_cycles = 2000;
      for (int i = 0; i < NUM_ROWS; i++) limit_cycles += row_len[i] + 20;
      limit_ready = 1'b1;

      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      expect_equal("busy after reset", busy, 0);
      expect_equal("wb_ack after reset", wb_ack, 0);
      expect_equal("out_x after reset", out_x, 0);
      expect_equal("out_y after reset", out_y, 0);
      @(negedge clk);

      for (int i = 0; i < NUM_ROWS; i++) run_row(i);

      assert_errors = ff_pulser_top_i.chan_x_i.checker_i.fail_count
                      + ff_pulser_top_i.chan_y_i.checker_i.fail_count;
      $display("Checks done: %0d value errors, %0d bus errors, %0d assertion errors",
               value_errors, bus_errors, assert_errors);
      if (value_errors == 0 && bus_errors == 0 && assert_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/pulser_pkg.sv
verilog/pulse_regs.sv
verilog/pulse_sequencer.sv
verilog/slew_channel.sv
verilog/ff_pulser_top.sv
sim/ff_pulser_checker.sv
sim/ff_pulser_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module ff_pulser_tb --Mdir obj_dir -o ff_pulser_sim
	./obj_dir/ff_pulser_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
